//--- hdl/ppu_pkg.sv
package ppu_pkg;

	// Screen coordinate, both axes wrap at 512
	typedef struct packed {
		logic [8:0] row;
		logic [8:0] col;
	} screen_pos_t;

	// One sprite slice, palette entry k sits in colors byte k
	typedef struct packed {
		logic [7:0]  pattern_low;
		logic [7:0]  pattern_high;
		logic [7:0]  attr;
		logic [31:0] colors;
	} sprite_src_t;

	// Background slice has no attribute byte, it never flips
	typedef struct packed {
		logic [7:0]  pattern_low;
		logic [7:0]  pattern_high;
		logic [31:0] colors;
	} bg_src_t;

	// Eight palette bytes, leftmost pixel in bits 63:56
	typedef logic [63:0] pixel_row_t;

	// Frame buffer write port
	typedef struct packed {
		logic [8:0] row;
		logic [8:0] col;
		logic [7:0] data;
		logic       wr_en;
	} vga_wr_t;

	typedef enum logic {
		STATE_IDLE,
		STATE_DRAW
	} render_state_t;

	// Control byte and attribute bit positions
	localparam int CTRL2_SHOW_BG  = 3;
	localparam int CTRL2_SHOW_SPR = 4;
	localparam int ATTR_HFLIP     = 6;

	localparam int SPAN_PIXELS = 8;

endpackage

//--- hdl/bus_pkg.sv
package bus_pkg;

	localparam int AXIL_ADDR_W = 6;
	localparam int AXIL_DATA_W = 32;

	typedef enum logic [1:0] {
		RESP_OKAY   = 2'b00,
		RESP_SLVERR = 2'b10
	} axil_resp_t;

	// Master side of the AXI4-Lite port
	typedef struct packed {
		logic [AXIL_ADDR_W-1:0]   awaddr;
		logic                     awvalid;
		logic [AXIL_DATA_W-1:0]   wdata;
		logic [AXIL_DATA_W/8-1:0] wstrb;
		logic                     wvalid;
		logic                     bready;
		logic [AXIL_ADDR_W-1:0]   araddr;
		logic                     arvalid;
		logic                     rready;
	} axil_req_t;

	// Slave side of the AXI4-Lite port
	typedef struct packed {
		logic                   awready;
		logic                   wready;
		logic                   arready;
		axil_resp_t             bresp;
		logic                   bvalid;
		logic [AXIL_DATA_W-1:0] rdata;
		axil_resp_t             rresp;
		logic                   rvalid;
	} axil_rsp_t;

	// Byte addresses of the 32-bit registers
	typedef enum logic [AXIL_ADDR_W-1:0] {
		REG_CTRL2    = 6'h00,
		REG_POS      = 6'h04,
		REG_SPR0_PAT = 6'h08,
		REG_SPR0_COL = 6'h0C,
		REG_SPR1_PAT = 6'h10,
		REG_SPR1_COL = 6'h14,
		REG_BG_PAT   = 6'h18,
		REG_BG_COL   = 6'h1C,
		REG_CMD      = 6'h20,
		REG_STATUS   = 6'h24
	} reg_addr_t;

endpackage

//--- hdl/color_selector.sv
`timescale 1ns/1ns

module color_selector import ppu_pkg::*; (
	input  logic [7:0]  pattern_low,
	input  logic [7:0]  pattern_high,
	input  logic        hflip,
	input  logic [31:0] colors,
	output pixel_row_t  pixels,
	output logic [7:0]  opaque
);

	// One lookup per pixel, pixel 0 is the leftmost on screen
	for (genvar i = 0; i < SPAN_PIXELS; i++) begin : g_pixel
		logic [2:0] bit_sel;
		logic [1:0] index;

		// Unflipped tiles read the pattern MSB first
		assign bit_sel = hflip ? 3'(i) : 3'(SPAN_PIXELS - 1 - i);

		// High plane gives the upper index bit
		assign index = {pattern_high[bit_sel], pattern_low[bit_sel]};

		// Palette byte k lives in colors byte k
		assign pixels[8*(SPAN_PIXELS-1-i) +: 8] = colors[{index, 3'b000} +: 8];

		// Opaque bit lines up with its byte, bit 7 is pixel 0
		assign opaque[SPAN_PIXELS-1-i] = |index;
	end

endmodule

//--- hdl/pixel_mux.sv
`timescale 1ns/1ns

module pixel_mux import ppu_pkg::*; (
	input  sprite_src_t sprite_0,
	input  sprite_src_t sprite_1,
	input  bg_src_t     background,
	input  logic [7:0]  ctrl2,
	output pixel_row_t  pixels
);

	pixel_row_t spr0_pixels;
	pixel_row_t spr1_pixels;
	pixel_row_t bg_pixels;
	logic [7:0] spr0_opaque;
	logic [7:0] spr1_opaque;
	logic [7:0] bg_opaque;
	logic       show_spr;
	logic       show_bg;
	logic [7:0] backdrop;

	// Sprite 0 layer
	color_selector spr0_sel_i (
		.pattern_low  (sprite_0.pattern_low),
		.pattern_high (sprite_0.pattern_high),
		.hflip        (sprite_0.attr[ATTR_HFLIP]),
		.colors       (sprite_0.colors),
		.pixels       (spr0_pixels),
		.opaque       (spr0_opaque)
	);

	// Sprite 1 layer
	color_selector spr1_sel_i (
		.pattern_low  (sprite_1.pattern_low),
		.pattern_high (sprite_1.pattern_high),
		.hflip        (sprite_1.attr[ATTR_HFLIP]),
		.colors       (sprite_1.colors),
		.pixels       (spr1_pixels),
		.opaque       (spr1_opaque)
	);

	// Background, never mirrored
	color_selector bg_sel_i (
		.pattern_low  (background.pattern_low),
		.pattern_high (background.pattern_high),
		.hflip        (1'b0),
		.colors       (background.colors),
		.pixels       (bg_pixels),
		.opaque       (bg_opaque)
	);

	assign show_spr = ctrl2[CTRL2_SHOW_SPR];
	assign show_bg  = ctrl2[CTRL2_SHOW_BG];

	// Shown when every layer is transparent or disabled
	assign backdrop = background.colors[7:0];

	// Fixed priority per pixel, sprite 0 wins
	for (genvar i = 0; i < SPAN_PIXELS; i++) begin : g_prio
		always_comb begin
			if (show_spr && spr0_opaque[i]) begin
				pixels[8*i +: 8] = spr0_pixels[8*i +: 8];
			end else if (show_spr && spr1_opaque[i]) begin
				pixels[8*i +: 8] = spr1_pixels[8*i +: 8];
			end else if (show_bg && bg_opaque[i]) begin
				pixels[8*i +: 8] = bg_pixels[8*i +: 8];
			end else begin
				pixels[8*i +: 8] = backdrop;
			end
		end
	end

endmodule

//--- hdl/render_8_pixels.sv
`timescale 1ns/1ns

module render_8_pixels import ppu_pkg::*; (
	input  logic        clk,
	input  logic        rst,
	input  logic        start,
	input  screen_pos_t start_pos,
	input  sprite_src_t sprite_0,
	input  sprite_src_t sprite_1,
	input  bg_src_t     background,
	input  logic [7:0]  ctrl2,
	output logic        busy,
	output vga_wr_t     vga_wr
);

	render_state_t state;
	pixel_row_t    pixels;
	logic [2:0]    offset;
	logic [2:0]    next_sel;

	// Inputs are held steady by the register block while drawing
	pixel_mux pixel_mux_i (
		.sprite_0   (sprite_0),
		.sprite_1   (sprite_1),
		.background (background),
		.ctrl2      (ctrl2),
		.pixels     (pixels)
	);

	// Pixel currently on the port, derived from the column
	// Modulo 512 subtraction keeps this right across the wrap
	assign offset = 3'(vga_wr.col - start_pos.col);

	// Byte of the row for the following pixel
	assign next_sel = 3'(SPAN_PIXELS - 2) - offset;

	assign busy = (state == STATE_DRAW);

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			state  <= STATE_IDLE;
			vga_wr <= '0;
		end else begin
			case (state)
				STATE_IDLE: begin
					if (start) begin
						state        <= STATE_DRAW;
						vga_wr.wr_en <= 1'b1;
						// Latch position, first pixel goes out right away
						vga_wr.row   <= start_pos.row;
						vga_wr.col   <= start_pos.col;
						vga_wr.data  <= pixels[63:56];
					end else begin
						vga_wr.wr_en <= 1'b0;
					end
				end
				STATE_DRAW: begin
					if (offset == 3'(SPAN_PIXELS - 1)) begin
						// Last pixel was on the port this cycle
						state        <= STATE_IDLE;
						vga_wr.wr_en <= 1'b0;
					end else begin
						vga_wr.wr_en <= 1'b1;
						vga_wr.col   <= vga_wr.col + 9'd1;
						vga_wr.data  <= pixels[{next_sel, 3'b000} +: 8];
					end
				end
				default: begin
					state        <= STATE_IDLE;
					vga_wr.wr_en <= 1'b0;
				end
			endcase
		end
	end

	// Writes only happen inside a draw
	assert property (@(posedge clk) disable iff (!rst)
		vga_wr.wr_en |-> busy);

	// Back to back writes walk the columns one at a time
	assert property (@(posedge clk) disable iff (!rst)
		vga_wr.wr_en && $past(vga_wr.wr_en) |-> vga_wr.col == 9'($past(vga_wr.col) + 9'd1));

endmodule

//--- hdl/render_regs.sv
`timescale 1ns/1ns

module render_regs import bus_pkg::*, ppu_pkg::*; (
	input  logic        clk,
	input  logic        rst,
	input  axil_req_t   axil_req,
	output axil_rsp_t   axil_rsp,
	input  logic        busy,
	output logic        start,
	output screen_pos_t start_pos,
	output sprite_src_t sprite_0,
	output sprite_src_t sprite_1,
	output bg_src_t     background,
	output logic [7:0]  ctrl2
);

	logic                   wr_ready;
	logic                   rd_ready;
	logic                   bvalid;
	logic                   rvalid;
	axil_resp_t             bresp;
	axil_resp_t             rresp;
	logic [AXIL_DATA_W-1:0] rdata;
	reg_addr_t              wr_addr;
	reg_addr_t              rd_addr;
	logic [AXIL_DATA_W-1:0] wr_word;
	logic                   wr_err;
	logic                   lock;

	// Current contents of a register as the host sees it
	function automatic logic [AXIL_DATA_W-1:0] reg_word(input reg_addr_t addr);
		case (addr)
			REG_CTRL2:    return {24'd0, ctrl2};
			REG_POS:      return {7'd0, start_pos.row, 7'd0, start_pos.col};
			REG_SPR0_PAT: return {8'd0, sprite_0.attr, sprite_0.pattern_high, sprite_0.pattern_low};
			REG_SPR0_COL: return sprite_0.colors;
			REG_SPR1_PAT: return {8'd0, sprite_1.attr, sprite_1.pattern_high, sprite_1.pattern_low};
			REG_SPR1_COL: return sprite_1.colors;
			REG_BG_PAT:   return {16'd0, background.pattern_high, background.pattern_low};
			REG_BG_COL:   return background.colors;
			REG_STATUS:   return {31'd0, busy};
			default:      return '0;
		endcase
	endfunction

	function automatic logic is_mapped(input reg_addr_t addr);
		case (addr)
			REG_CTRL2, REG_POS, REG_SPR0_PAT, REG_SPR0_COL, REG_SPR1_PAT,
			REG_SPR1_COL, REG_BG_PAT, REG_BG_COL, REG_CMD, REG_STATUS: return 1'b1;
			default: return 1'b0;
		endcase
	endfunction

	// Byte strobes pick between new data and the old value
	function automatic logic [AXIL_DATA_W-1:0] merge_strb(
		input logic [AXIL_DATA_W-1:0]   cur,
		input logic [AXIL_DATA_W-1:0]   data,
		input logic [AXIL_DATA_W/8-1:0] strb
	);
		logic [AXIL_DATA_W-1:0] res;
		res = cur;
		for (int b = 0; b < AXIL_DATA_W/8; b++) begin
			if (strb[b])
				res[8*b +: 8] = data[8*b +: 8];
		end
		return res;
	endfunction

	// Start pulse counts as busy, the renderer sees it one cycle later
	assign lock = busy | start;

	// AW and W accepted together, one outstanding response each way
	assign wr_ready = axil_req.awvalid & axil_req.wvalid & ~bvalid;
	assign rd_ready = axil_req.arvalid & ~rvalid;

	always_comb begin
		wr_addr = reg_addr_t'(axil_req.awaddr);
		rd_addr = reg_addr_t'(axil_req.araddr);
		wr_word = merge_strb(reg_word(wr_addr), axil_req.wdata, axil_req.wstrb);
		// While drawing only a CMD write without start goes through
		wr_err  = !is_mapped(wr_addr) || (lock && (wr_addr != REG_CMD || wr_word[0]));
	end

	// Write channel and register updates
	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			bvalid     <= 1'b0;
			bresp      <= RESP_OKAY;
			start      <= 1'b0;
			ctrl2      <= '0;
			start_pos  <= '0;
			sprite_0   <= '0;
			sprite_1   <= '0;
			background <= '0;
		end else begin
			start <= 1'b0;
			if (bvalid && axil_req.bready)
				bvalid <= 1'b0;
			if (wr_ready) begin
				bvalid <= 1'b1;
				bresp  <= wr_err ? RESP_SLVERR : RESP_OKAY;
				if (!wr_err) begin
					case (wr_addr)
						REG_CTRL2: ctrl2 <= wr_word[7:0];
						REG_POS: begin
							start_pos.row <= wr_word[24:16];
							start_pos.col <= wr_word[8:0];
						end
						REG_SPR0_PAT: begin
							sprite_0.pattern_low  <= wr_word[7:0];
							sprite_0.pattern_high <= wr_word[15:8];
							sprite_0.attr         <= wr_word[23:16];
						end
						REG_SPR0_COL: sprite_0.colors <= wr_word;
						REG_SPR1_PAT: begin
							sprite_1.pattern_low  <= wr_word[7:0];
							sprite_1.pattern_high <= wr_word[15:8];
							sprite_1.attr         <= wr_word[23:16];
						end
						REG_SPR1_COL: sprite_1.colors <= wr_word;
						REG_BG_PAT: begin
							background.pattern_low  <= wr_word[7:0];
							background.pattern_high <= wr_word[15:8];
						end
						REG_BG_COL: background.colors <= wr_word;
						REG_CMD:    start <= wr_word[0];
						// STATUS is read only
						default: ;
					endcase
				end
			end
		end
	end

	// Read channel, data registered with the response
	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			rvalid <= 1'b0;
			rresp  <= RESP_OKAY;
			rdata  <= '0;
		end else begin
			if (rvalid && axil_req.rready)
				rvalid <= 1'b0;
			if (rd_ready) begin
				rvalid <= 1'b1;
				rdata  <= reg_word(rd_addr);
				rresp  <= is_mapped(rd_addr) ? RESP_OKAY : RESP_SLVERR;
			end
		end
	end

	assign axil_rsp = '{awready: wr_ready, wready: wr_ready, arready: rd_ready,
		bresp: bresp, bvalid: bvalid, rdata: rdata, rresp: rresp, rvalid: rvalid};

	// Response held until the master takes it
	assert property (@(posedge clk) disable iff (!rst)
		bvalid && !axil_req.bready |=> bvalid);

	// Renderer never gets a second start mid span
	assert property (@(posedge clk) disable iff (!rst)
		start |-> !busy);

endmodule

//--- hdl/render_top.sv
`timescale 1ns/1ns

module render_top import bus_pkg::*, ppu_pkg::*; (
	input  logic      clk,
	input  logic      rst,
	input  axil_req_t axil_req,
	output axil_rsp_t axil_rsp,
	output vga_wr_t   vga_wr
);

	// Register block to renderer
	logic        start;
	logic        busy;
	screen_pos_t start_pos;
	sprite_src_t sprite_0;
	sprite_src_t sprite_1;
	bg_src_t     background;
	logic [7:0]  ctrl2;

	// Host side registers and command
	render_regs regs_i (
		.clk        (clk),
		.rst        (rst),
		.axil_req   (axil_req),
		.axil_rsp   (axil_rsp),
		.busy       (busy),
		.start      (start),
		.start_pos  (start_pos),
		.sprite_0   (sprite_0),
		.sprite_1   (sprite_1),
		.background (background),
		.ctrl2      (ctrl2)
	);

	// Span renderer drives the frame buffer port directly
	render_8_pixels render_i (
		.clk        (clk),
		.rst        (rst),
		.start      (start),
		.start_pos  (start_pos),
		.sprite_0   (sprite_0),
		.sprite_1   (sprite_1),
		.background (background),
		.ctrl2      (ctrl2),
		.busy       (busy),
		.vga_wr     (vga_wr)
	);

endmodule

//--- dv/render_tb.sv
`timescale 1ns/1ns

module render_tb import bus_pkg::*, ppu_pkg::*; ();

	// One span setup and the bytes it should draw, leftmost in the top byte
	typedef struct packed {
		logic [7:0]  ctrl2;
		screen_pos_t pos;
		sprite_src_t spr0;
		sprite_src_t spr1;
		bg_src_t     bg;
		pixel_row_t  expect_row;
	} span_case_t;

	localparam int NUM_ROWS   = 6;
	localparam int NUM_RANDOM = 40;
	localparam int WAIT_LIMIT = 50;

	logic        clk;
	logic        rst;
	axil_req_t   axil_req;
	axil_rsp_t   axil_rsp;
	vga_wr_t     vga_wr;
	span_case_t  table_rows [NUM_ROWS];
	string       table_names [NUM_ROWS];
	vga_wr_t     captured [$];
	logic [31:0] lfsr;
	int          errors;
	int          tests;
	event        timeout_ev;

	render_top dut_i (
		.clk      (clk),
		.rst      (rst),
		.axil_req (axil_req),
		.axil_rsp (axil_rsp),
		.vga_wr   (vga_wr)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// Frame buffer port is registered, stable at the falling edge
	always @(negedge clk) begin
		if (rst && vga_wr.wr_en)
			captured.push_back(vga_wr);
	end

	// A wait that gives up ends the run here
	initial begin
		@(timeout_ev);
		$display("Testbench failed");
		$finish;
	end

	task automatic abort_run(input string why);
		$display("Timeout: %s", why);
		-> timeout_ev;
		// The caller goes no further while the run ends
		forever @(negedge clk);
	endtask

	task automatic check_value(input string name, input logic [63:0] exp, input logic [63:0] got);
		assert (got === exp)
		else begin
			$display("ERR %s expected %h got %h", name, exp, got);
			errors++;
		end
	endtask

	task automatic report_test(input string name, input int first_err);
		tests++;
		if (errors == first_err)
			$display("%s ok", name);
		else
			$display("%s FAILED with %0d errors", name, errors - first_err);
	endtask

	// Fibonacci LFSR, taps 32 22 2 1, one step per bit handed out
	function automatic logic [31:0] next_bits(input int n);
		logic [31:0] val;
		logic        fb;
		val = '0;
		for (int k = 0; k < n; k++) begin
			fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
			lfsr = {lfsr[30:0], fb};
			val  = {val[30:0], fb};
		end
		return val;
	endfunction

	// Two bit index of one layer pixel, MSB first unless mirrored
	function automatic logic [1:0] layer_index(input logic [7:0] low, input logic [7:0] high,
			input logic flip, input int pix);
		int b;
		b = flip ? pix : 7 - pix;
		return {high[b], low[b]};
	endfunction

	// Expected row, sprite 0 then sprite 1 then background then backdrop
	function automatic pixel_row_t ref_row(input span_case_t c);
		pixel_row_t row;
		logic [7:0] pix;
		logic [1:0] i0;
		logic [1:0] i1;
		logic [1:0] ib;
		logic       show_spr;
		logic       show_bg;
		show_spr = c.ctrl2[CTRL2_SHOW_SPR];
		show_bg  = c.ctrl2[CTRL2_SHOW_BG];
		for (int p = 0; p < SPAN_PIXELS; p++) begin
			i0 = layer_index(c.spr0.pattern_low, c.spr0.pattern_high, c.spr0.attr[ATTR_HFLIP], p);
			i1 = layer_index(c.spr1.pattern_low, c.spr1.pattern_high, c.spr1.attr[ATTR_HFLIP], p);
			ib = layer_index(c.bg.pattern_low, c.bg.pattern_high, 1'b0, p);
			if (show_spr && i0 != 2'd0)
				pix = c.spr0.colors[8*i0 +: 8];
			else if (show_spr && i1 != 2'd0)
				pix = c.spr1.colors[8*i1 +: 8];
			else if (show_bg && ib != 2'd0)
				pix = c.bg.colors[8*ib +: 8];
			else
				pix = c.bg.colors[7:0];
			row[8*(SPAN_PIXELS-1-p) +: 8] = pix;
		end
		return row;
	endfunction

	task automatic axil_write(input logic [AXIL_ADDR_W-1:0] addr, input logic [31:0] data,
			output axil_resp_t resp);
		int count;
		count = 0;
		@(negedge clk);
		axil_req.awaddr  = addr;
		axil_req.awvalid = 1'b1;
		axil_req.wdata   = data;
		axil_req.wstrb   = 4'hF;
		axil_req.wvalid  = 1'b1;
		// AW and W transfer together on a rising edge with both readies high
		@(posedge clk);
		while (!(axil_rsp.awready && axil_rsp.wready)) begin
			if (count >= WAIT_LIMIT)
				abort_run("address and data never accepted by the register block");
			else begin
				count++;
				@(posedge clk);
			end
		end
		@(negedge clk);
		axil_req.awvalid = 1'b0;
		axil_req.wvalid  = 1'b0;
		// Response is raised by the accepting edge
		count = 0;
		while (!axil_rsp.bvalid) begin
			if (count >= WAIT_LIMIT)
				abort_run("no write response from the register block");
			else begin
				count++;
				@(negedge clk);
			end
		end
		resp = axil_rsp.bresp;
	endtask

	task automatic axil_read(input logic [AXIL_ADDR_W-1:0] addr, output logic [31:0] data,
			output axil_resp_t resp);
		int count;
		count = 0;
		@(negedge clk);
		axil_req.araddr  = addr;
		axil_req.arvalid = 1'b1;
		@(posedge clk);
		while (!axil_rsp.arready) begin
			if (count >= WAIT_LIMIT)
				abort_run("read address never accepted by the register block");
			else begin
				count++;
				@(posedge clk);
			end
		end
		@(negedge clk);
		axil_req.arvalid = 1'b0;
		count = 0;
		while (!axil_rsp.rvalid) begin
			if (count >= WAIT_LIMIT)
				abort_run("no read response from the register block");
			else begin
				count++;
				@(negedge clk);
			end
		end
		data = axil_rsp.rdata;
		resp = axil_rsp.rresp;
	endtask

	task automatic write_ok(input logic [AXIL_ADDR_W-1:0] addr, input logic [31:0] data);
		axil_resp_t resp;
		axil_write(addr, data, resp);
		check_value($sformatf("bresp @%h", addr), 64'(RESP_OKAY), 64'(resp));
	endtask

	// STATUS polled until busy drops
	task automatic wait_idle();
		logic [31:0] status;
		axil_resp_t  resp;
		int          count;
		count  = 0;
		status = 32'd1;
		while (status[0]) begin
			if (count >= WAIT_LIMIT)
				abort_run("renderer stayed busy");
			else begin
				count++;
				axil_read(REG_STATUS, status, resp);
			end
		end
	endtask

	task automatic load_layers(input span_case_t c);
		write_ok(REG_CTRL2, {24'd0, c.ctrl2});
		write_ok(REG_POS, {7'd0, c.pos.row, 7'd0, c.pos.col});
		write_ok(REG_SPR0_PAT, {8'd0, c.spr0.attr, c.spr0.pattern_high, c.spr0.pattern_low});
		write_ok(REG_SPR0_COL, c.spr0.colors);
		write_ok(REG_SPR1_PAT, {8'd0, c.spr1.attr, c.spr1.pattern_high, c.spr1.pattern_low});
		write_ok(REG_SPR1_COL, c.spr1.colors);
		write_ok(REG_BG_PAT, {16'd0, c.bg.pattern_high, c.bg.pattern_low});
		write_ok(REG_BG_COL, c.bg.colors);
	endtask

	// Eight writes on one row, columns in order and wrapping at 512
	task automatic check_span(input string name, input span_case_t c);
		vga_wr_t w;
		check_value({name, " write count"}, 64'(SPAN_PIXELS), 64'(captured.size()));
		for (int k = 0; k < captured.size() && k < SPAN_PIXELS; k++) begin
			w = captured[k];
			check_value($sformatf("%s vga_wr.row[%0d]", name, k), 64'(c.pos.row), 64'(w.row));
			check_value($sformatf("%s vga_wr.col[%0d]", name, k),
				64'(9'(c.pos.col + 9'(k))), 64'(w.col));
			check_value($sformatf("%s vga_wr.data[%0d]", name, k),
				64'(c.expect_row[8*(SPAN_PIXELS-1-k) +: 8]), 64'(w.data));
		end
	endtask

	task automatic run_span(input string name, input span_case_t c);
		int first_err;
		first_err = errors;
		load_layers(c);
		captured.delete();
		write_ok(REG_CMD, 32'd1);
		wait_idle();
		check_span(name, c);
		report_test(name, first_err);
	endtask

	task automatic readback_test();
		reg_addr_t   addrs [8] = '{REG_CTRL2, REG_POS, REG_SPR0_PAT, REG_SPR0_COL,
			REG_SPR1_PAT, REG_SPR1_COL, REG_BG_PAT, REG_BG_COL};
		logic [31:0] words [8] = '{32'h0000_00A5, 32'h0155_01AA, 32'h00C3_5A3C, 32'h8E4F_1C27,
			32'h0041_9966, 32'h5A5A_C3C3, 32'h0000_F00F, 32'h0123_4567};
		logic [31:0] data;
		axil_resp_t  resp;
		int          first_err;
		first_err = errors;
		for (int i = 0; i < 8; i++)
			write_ok(addrs[i], words[i]);
		for (int i = 0; i < 8; i++) begin
			axil_read(addrs[i], data, resp);
			check_value($sformatf("rresp @%h", addrs[i]), 64'(RESP_OKAY), 64'(resp));
			check_value($sformatf("rdata @%h", addrs[i]), 64'(words[i]), 64'(data));
		end
		// Holes in the map
		axil_read(6'h28, data, resp);
		check_value("rresp @28", 64'(RESP_SLVERR), 64'(resp));
		check_value("rdata @28", 64'd0, 64'(data));
		axil_read(6'h3C, data, resp);
		check_value("rresp @3c", 64'(RESP_SLVERR), 64'(resp));
		check_value("rdata @3c", 64'd0, 64'(data));
		report_test("register readback", first_err);
	endtask

	// Layer write and restart during a draw must bounce
	task automatic busy_test();
		logic [31:0] status;
		axil_resp_t  resp;
		int          first_err;
		first_err = errors;
		load_layers(table_rows[0]);
		captured.delete();
		write_ok(REG_CMD, 32'd1);
		axil_read(REG_STATUS, status, resp);
		check_value("STATUS busy", 64'd1, 64'(status));
		// Background colors feed the last pixels of the span
		axil_write(REG_BG_COL, 32'hFFFF_FFFF, resp);
		check_value("bresp BG_COL while busy", 64'(RESP_SLVERR), 64'(resp));
		axil_write(REG_CMD, 32'd1, resp);
		check_value("bresp second start", 64'(RESP_SLVERR), 64'(resp));
		wait_idle();
		check_span("busy", table_rows[0]);
		report_test("busy protection", first_err);
	endtask

	task automatic random_test(input int n);
		span_case_t c;
		c.ctrl2             = 8'(next_bits(8));
		c.pos.row           = 9'(next_bits(9));
		c.pos.col           = 9'(next_bits(9));
		c.spr0.pattern_low  = 8'(next_bits(8));
		c.spr0.pattern_high = 8'(next_bits(8));
		c.spr0.attr         = 8'(next_bits(8));
		c.spr0.colors       = next_bits(32);
		c.spr1.pattern_low  = 8'(next_bits(8));
		c.spr1.pattern_high = 8'(next_bits(8));
		c.spr1.attr         = 8'(next_bits(8));
		c.spr1.colors       = next_bits(32);
		c.bg.pattern_low    = 8'(next_bits(8));
		c.bg.pattern_high   = 8'(next_bits(8));
		c.bg.colors         = next_bits(32);
		c.expect_row        = ref_row(c);
		run_span($sformatf("random span %0d", n), c);
	endtask

	// Fixed palettes, entry k of each layer is 0x10*layer + k
	function automatic span_case_t make_case(input logic [7:0] ctrl2, input logic [8:0] row,
			input logic [8:0] col, input logic [23:0] s0, input logic [23:0] s1,
			input logic [15:0] bg, input pixel_row_t exp);
		span_case_t c;
		c.ctrl2      = ctrl2;
		c.pos.row    = row;
		c.pos.col    = col;
		c.spr0       = {s0, 32'h1312_1110};
		c.spr1       = {s1, 32'h2322_2120};
		c.bg         = {bg, 32'h3332_3130};
		c.expect_row = exp;
		return c;
	endfunction

	// Sprite fields are low, high, attr and background is low, high
	task automatic fill_table();
		table_names[0] = "priority";
		table_rows[0]  = make_case(8'h18, 9'd5, 9'd100, 24'hF0_00_00, 24'hCC_CC_00,
			16'h00_AA, 64'h1111_1111_2323_3230);
		table_names[1] = "all transparent";
		table_rows[1]  = make_case(8'h18, 9'd6, 9'd0, 24'h0, 24'h0, 16'h0,
			64'h3030_3030_3030_3030);
		table_names[2] = "hflip";
		table_rows[2]  = make_case(8'h18, 9'd100, 9'd300, 24'h01_01_E0, 24'h00_06_40,
			16'h01_00, 64'h1322_2230_3030_3031);
		table_names[3] = "sprites off wrap";
		table_rows[3]  = make_case(8'h08, 9'd200, 9'd508, 24'hF0_00_00, 24'hCC_CC_00,
			16'h00_AA, 64'h3230_3230_3230_3230);
		table_names[4] = "background off";
		table_rows[4]  = make_case(8'h10, 9'd511, 9'd511, 24'hF0_00_00, 24'hCC_CC_00,
			16'h00_AA, 64'h1111_1111_2323_3030);
		table_names[5] = "layers off";
		table_rows[5]  = make_case(8'hE7, 9'd0, 9'd504, 24'hF0_00_00, 24'hCC_CC_00,
			16'h00_AA, 64'h3030_3030_3030_3030);
	endtask

	initial begin
		rst             = 1'b0;
		axil_req        = '0;
		axil_req.bready = 1'b1;
		axil_req.rready = 1'b1;
		lfsr            = 32'h9761_08d2;
		errors          = 0;
		tests           = 0;
		fill_table();
		repeat (8) @(posedge clk);
		@(negedge clk);
		rst = 1'b1;
		readback_test();
		for (int i = 0; i < NUM_ROWS; i++)
			run_span(table_names[i], table_rows[i]);
		busy_test();
		for (int i = 0; i < NUM_RANDOM; i++)
			random_test(i);
		$display("%0d tests run, %0d errors", tests, errors);
		if (errors == 0)
			$display("Testbench passed");
		else
			$display("Testbench failed");
		$finish;
	end

endmodule

//--- all.f
hdl/ppu_pkg.sv
hdl/bus_pkg.sv
hdl/color_selector.sv
hdl/pixel_mux.sv
hdl/render_8_pixels.sv
hdl/render_regs.sv
hdl/render_top.sv
dv/render_tb.sv

//--- Makefile
SIM      = verilator
TOP      = render_tb
FILELIST = all.f
FLAGS    = --binary --timing --assert -j 0 -Wno-fatal
OBJ_DIR  = obj_dir

BIN     = $(OBJ_DIR)/V$(TOP)
SOURCES = $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: $(BIN)

# Rebuilt only when a source or the file list changes
$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Pass only when the testbench prints its pass line
run: $(BIN)
	@out="$$($(BIN))"; echo "$$out"; echo "$$out" | grep -qx 'Testbench passed'

clean:
	rm -rf $(OBJ_DIR)
